// File: gf3_mult.f
+incdir+common
+incdir+sim
common/gf3_pkg.sv
f3m_mult/f3m_shift_x3.sv
f3m_mult/f3m_digit_mac.sv
f3m_mult/f3m_mult.sv
sim/tb_f3m_mult.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_f3m_mult \
    -f gf3_mult.f -o tb_f3m_mult || { echo "verilator build failed"; exit 1; }
result=$(./obj_dir/tb_f3m_mult)
echo "$result"
echo "$result" | grep -qF "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim/gf3_ref.svh
`ifndef GF3_REF_SVH
`define GF3_REF_SVH

// software model of the field product on plain integers mod 3

// value 0..2 of trit i, code 11 reads as 3 and spoils the result
function automatic int trit_at(input elem_t e, input int i);
    return int'(e[2*i +: 2]);
endfunction

// schoolbook product of a and b, then folded with x^97 = 2*x^12 + 1
function automatic elem_t ref_mult(input elem_t a, input elem_t b);
    int    prod [2*`GF_M-1];
    int    i;
    int    j;
    int    t;
    elem_t r;

    for (i = 0; i < 2*`GF_M-1; i++)
    begin
        prod[i] = 0;
    end

    for (i = 0; i < `GF_M; i++)
    begin
        for (j = 0; j < `GF_M; j++)
        begin
            prod[i+j] = (prod[i+j] + trit_at(a, i) * trit_at(b, j)) % 3;
        end
    end

    // walk down from the top so folded terms above 96 get folded again
    for (i = 2*`GF_M-2; i >= `GF_M; i--)
    begin
        t = prod[i];
        prod[i] = 0;
        prod[i-`GF_M] = (prod[i-`GF_M] + t) % 3;
        prod[i-`GF_M+`GF_TAP] = (prod[i-`GF_M+`GF_TAP] + 2*t) % 3;
    end

    r = '0;
    for (i = 0; i < `GF_M; i++)
    begin
        r[2*i +: 2] = 2'(prod[i]);
    end
    return r;
endfunction

// one trit of value coef at degree deg, all others zero
function automatic elem_t term(input int deg, input trit_t coef);
    elem_t e;

    e = '0;
    e[2*deg +: 2] = coef;
    return e;
endfunction

`endif

// File: sim/tb_f3m_mult.sv
`timescale 1ns/10ps
`default_nettype none

`include "gf3_defs.svh"

module tb_f3m_mult
    import gf3_pkg::*;
();

    `include "gf3_ref.svh"

    localparam int DONE_TIMEOUT = 100;              // cycles allowed for one product
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES  = 20;

    logic        clk;
    logic        reset;
    elem_t       a;
    elem_t       b;
    elem_t       c;
    logic        done;

    logic [31:0] lfsr;
    int          errors;
    int          tests;

    f3m_mult i_f3m_mult (
        .clk   (clk),
        .reset (reset),
        .a     (a),
        .b     (b),
        .c     (c),
        .done  (done)
    );

    always #2 clk = ~clk;                           // 4 ns period

    // galois form of x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'hD000_0001;
        else
            return s >> 1;
    endfunction

    task automatic draw_bit(output logic value);
        value = lfsr[0];
        lfsr  = lfsr_next(lfsr);
    endtask

    task automatic random_trit(output trit_t t);
        logic lo;
        logic hi;

        do
        begin
            draw_bit(lo);
            draw_bit(hi);
        end
        while ({hi, lo} == 2'b11);                  // invalid code is drawn again
        t = {hi, lo};
    endtask

    task automatic random_elem(output elem_t e);
        trit_t t;
        int    i;

        e = '0;
        for (i = 0; i < `GF_M; i++)
        begin
            random_trit(t);
            e[2*i +: 2] = t;
        end
    endtask

    task automatic check_elem(input string what, input elem_t got, input elem_t exp);
        assert (got === exp)
        else
        begin
            $display("FAILED at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("FAILED at %0d ns: %s, got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // operands are set with reset and released after the reset cycles
    task automatic start_run(input elem_t op_a, input elem_t op_b);
        @(negedge clk);
        a     = op_a;
        b     = op_b;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_done(output logic ok);
        int cycles;

        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        ok = (done === 1'b1);
        if (!ok)
        begin
            $display("timeout: done did not rise within %0d cycles after reset", DONE_TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_product(input string what, input elem_t op_a, input elem_t op_b,
                               input elem_t exp);
        logic ok;

        start_run(op_a, op_b);
        wait_done(ok);
        if (ok)
            check_elem(what, c, exp);
    endtask

    task automatic report_test(input string name, input int first);
        tests++;
        if (errors == first)
            $display("%s: ok", name);
        else
            $display("%s: %0d failed check(s)", name, errors - first);
    endtask

    // done must rise on edge 34 after reset falls, not before
    task automatic test_timing();
        int    first;
        int    k;
        elem_t op_a;
        elem_t op_b;

        first = errors;
        random_elem(op_a);
        random_elem(op_b);
        @(negedge clk);
        a     = op_a;
        b     = op_b;
        reset = 1'b1;
        for (k = 0; k < RESET_CYCLES; k++)
        begin
            @(negedge clk);
            check_bit("done during reset", done, 1'b0);
        end
        reset = 1'b0;
        for (k = 1; k <= `GF_STEPS + 1; k++)
        begin
            @(negedge clk);
            check_bit($sformatf("done after edge %0d", k), done, k > `GF_STEPS);
        end
        check_elem("product at first done", c, ref_mult(op_a, op_b));
        report_test("timing", first);
    endtask

    task automatic test_identity();
        int    first;
        elem_t op_a;

        first = errors;
        random_elem(op_a);
        run_product("a times one", op_a, term(0, 2'b01), op_a);
        run_product("a times zero", op_a, '0, '0);
        report_test("identity and zero", first);
    endtask

    task automatic test_reduction();
        int first;

        first = errors;
        run_product("x^96 times x", term(96, 2'b01), term(1, 2'b01),
                    term(12, 2'b10) | term(0, 2'b01));
        run_product("x^96 times x^2", term(96, 2'b01), term(2, 2'b01),
                    term(13, 2'b10) | term(1, 2'b01));
        report_test("reduction", first);
    endtask

    task automatic test_random();
        int    first;
        int    n;
        elem_t op_a;
        elem_t op_b;
        elem_t exp;

        first = errors;
        for (n = 0; n < 8; n++)
        begin
            random_elem(op_a);
            random_elem(op_b);
            exp = ref_mult(op_a, op_b);
            run_product($sformatf("random pair %0d", n), op_a, op_b, exp);
            run_product($sformatf("random pair %0d swapped", n), op_b, op_a, exp);
        end
        report_test("random products", first);
    endtask

    task automatic test_hold();
        int    first;
        int    k;
        logic  ok;
        elem_t op_a;
        elem_t op_b;
        elem_t held;

        first = errors;
        random_elem(op_a);
        random_elem(op_b);
        start_run(op_a, op_b);
        wait_done(ok);
        held = c;
        for (k = 0; k < HOLD_CYCLES; k++)
        begin
            @(negedge clk);
            check_elem("c after done", c, held);
            check_bit("done after done", done, 1'b1);
        end

        // a new run clears done and c moves only once the new product is ready
        random_elem(op_a);
        random_elem(op_b);
        a     = op_a;
        b     = op_b;
        reset = 1'b1;
        @(negedge clk);
        check_bit("done after next reset", done, 1'b0);
        check_elem("c during next reset", c, held);
        repeat (RESET_CYCLES - 1) @(negedge clk);
        reset = 1'b0;
        wait_done(ok);
        if (ok)
            check_elem("product of next run", c, ref_mult(op_a, op_b));
        report_test("hold", first);
    endtask

    initial
    begin
        clk    = 1'b0;
        reset  = 1'b1;
        a      = '0;
        b      = '0;
        lfsr   = 32'd21;
        errors = 0;
        tests  = 0;

        test_timing();
        test_identity();
        test_reduction();
        test_random();
        test_hold();

        $display("%0d tests run, %0d failed checks", tests, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: f3m_mult/f3m_mult.sv
`timescale 1ns/10ps
`default_nettype none

`include "gf3_defs.svh"

module f3m_mult
    import gf3_pkg::*;
(
    input  wire   clk,
    input  wire   reset,
    input  wire   elem_t a,
    input  wire   elem_t b,
    output elem_t c,
    output logic  done
);

    localparam elem_t LOW_BITS = {`GF_M{2'b01}};    // low bit of every trit

    // x runs through a * x^(3j), y hands out the digits of b, z sums the products
    elem_t x;
    elem_t y;
    elem_t z;
    elem_t x_next;
    elem_t z_next;

    logic [`GF_STEPS:0] step;                       // one-hot countdown
    logic               last;

    logic a_bad;
    logic b_bad;

    f3m_shift_x3 i_f3m_shift_x3 (
        .x (x),
        .y (x_next)
    );

    f3m_digit_mac i_f3m_digit_mac (
        .x     (x),
        .digit (y[2*`GF_DIGIT-1:0]),
        .acc   (z),
        .sum   (z_next)
    );

    assign last = step[0];                          // high after GF_STEPS edges

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            x    <= a;
            y    <= b;
            z    <= '0;
            step <= {1'b1, {`GF_STEPS{1'b0}}};
        end
        else
        begin
            x    <= x_next;
            y    <= y >> (2*`GF_DIGIT);             // next digit down, zeros shift in
            z    <= z_next;
            step <= step >> 1;
        end
    end

    // y is all zero by now, so z no longer moves and c holds it
    always_ff @(posedge clk)
    begin
        if (!reset && last)
            c <= z;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else if (last)
            done <= 1'b1;                           // sticky until the next reset
    end

    // a trit reading 11 has both of its bits set
    assign a_bad = |(a & (a >> 1) & LOW_BITS);
    assign b_bad = |(b & (b >> 1) & LOW_BITS);

    a_done_sticky: assert property (
        @(posedge clk) done && !reset |=> done
    ) else $error("done dropped without reset");

    a_step_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(step)
    ) else $error("step register lost its single one");

    // operands are taken on the last edge with reset high
    a_operands_valid: assert property (
        @(posedge clk) $fell(reset) |-> !$past(a_bad) && !$past(b_bad)
    ) else $error("operand holds an invalid trit code");

endmodule

`default_nettype wire

// File: f3m_mult/f3m_digit_mac.sv
`timescale 1ns/10ps
`default_nettype none

`include "gf3_defs.svh"

module f3m_digit_mac
    import gf3_pkg::*;
(
    input  wire elem_t  x,
    input  wire digit_t digit,
    input  wire elem_t  acc,
    output wire elem_t  sum
);

    localparam int M     = `GF_M;
    localparam int DIGIT = `GF_DIGIT;
    localparam int TAP   = `GF_TAP;
    localparam int PDEG  = M + DIGIT - 1;           // trits in the unreduced product

    trit_t prod [PDEG];                             // x * digit before reduction

    genvar i, k;

    // schoolbook product, trit i collects x[i-k] * digit[k]
    generate
        for (i = 0; i < PDEG; i++)
        begin : g_prod
            trit_t term [DIGIT];
            trit_t part [DIGIT+1];

            assign part[0] = 2'b00;

            for (k = 0; k < DIGIT; k++)
            begin : g_term
                if (i - k >= 0 && i - k < M)
                begin : g_on
                    assign term[k] = trit_mul(x[2*(i-k) +: 2], digit[2*k +: 2]);
                end
                else
                begin : g_off
                    assign term[k] = 2'b00;         // x has no trit at this degree
                end
                assign part[k+1] = trit_add(part[k], term[k]);
            end

            assign prod[i] = part[DIGIT];
        end
    endgenerate

    // Degrees M and M+1 come only from the top two trits of x. With
    // x^97 = 2*x^12 + 1 each of them goes unchanged into degree i-M and
    // doubled, which is negation mod 3, into degree i-M+TAP.
    generate
        for (i = 0; i < M; i++)
        begin : g_sum
            trit_t red;

            if (i < DIGIT - 1)
            begin : g_low
                assign red = trit_add(prod[i], prod[M+i]);
            end
            else if (i >= TAP && i < TAP + DIGIT - 1)
            begin : g_tap
                assign red = trit_add(prod[i], trit_neg(prod[M+i-TAP]));
            end
            else
            begin : g_plain
                assign red = prod[i];
            end

            assign sum[2*i +: 2] = trit_add(red, acc[2*i +: 2]);    // accumulate
        end
    endgenerate

endmodule

`default_nettype wire

// File: f3m_mult/f3m_shift_x3.sv
`timescale 1ns/10ps
`default_nettype none

`include "gf3_defs.svh"

module f3m_shift_x3
    import gf3_pkg::*;
(
    input  wire elem_t x,
    output wire elem_t y
);

    localparam int M     = `GF_M;
    localparam int SHIFT = `GF_DIGIT;
    localparam int TAP   = `GF_TAP;

    // y = x * x^3 mod p, with x^97 = 2*x^12 + 1
    // the top three trits land on degrees 97..99 and fold back twice:
    // once unchanged into 0..2 and once negated into TAP..TAP+2

    genvar i;
    generate
        for (i = 0; i < M; i++)
        begin : g_trit
            if (i < SHIFT)
            begin : g_wrap
                assign y[2*i +: 2] = x[2*(M-SHIFT+i) +: 2];     // constant term of the fold
            end
            else if (i >= TAP && i < TAP + SHIFT)
            begin : g_tap
                assign y[2*i +: 2] = trit_add(x[2*(i-SHIFT) +: 2],
                                              trit_neg(x[2*(M-SHIFT+i-TAP) +: 2]));
            end
            else
            begin : g_move
                assign y[2*i +: 2] = x[2*(i-SHIFT) +: 2];
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: common/gf3_pkg.sv
`default_nettype none

`include "gf3_defs.svh"

package gf3_pkg;

    typedef logic [1:0] trit_t;                     // 11 is never a valid code
    typedef logic [`GF_WIDTH-1:0] elem_t;           // trit i in bits 2i+1:2i
    typedef logic [2*`GF_DIGIT-1:0] digit_t;        // low trit in bits 1:0

    // sum of two trits modulo 3
    function automatic trit_t trit_add(input trit_t a, input trit_t b);
        trit_t s;
        case ({a, b})
            4'b00_00: s = 2'b00;
            4'b00_01: s = 2'b01;
            4'b00_10: s = 2'b10;
            4'b01_00: s = 2'b01;
            4'b01_01: s = 2'b10;
            4'b01_10: s = 2'b00;                    // 1 + 2 wraps to 0
            4'b10_00: s = 2'b10;
            4'b10_01: s = 2'b00;
            4'b10_10: s = 2'b01;                    // 2 + 2 wraps to 1
            default:  s = 2'bxx;
        endcase
        return s;
    endfunction

    // -t mod 3 just swaps 1 and 2, and 0 stays put
    function automatic trit_t trit_neg(input trit_t t);
        return {t[0], t[1]};
    endfunction

    // product of two trits modulo 3
    function automatic trit_t trit_mul(input trit_t a, input trit_t b);
        trit_t p;
        case ({a, b})
            4'b01_01: p = 2'b01;
            4'b01_10: p = 2'b10;
            4'b10_01: p = 2'b10;
            4'b10_10: p = 2'b01;                    // 2 * 2 = 4 = 1
            default:  p = 2'b00;                    // either side zero
        endcase
        return p;
    endfunction

endpackage

`default_nettype wire

// File: common/gf3_defs.svh
`ifndef GF3_DEFS_SVH
`define GF3_DEFS_SVH

// degree of the irreducible polynomial x^97 + x^12 + 2
`define GF_M 97

// each trit takes two bits, 00 = 0, 01 = 1, 10 = 2
`define GF_WIDTH (2 * `GF_M)

// trits of b consumed per clock
`define GF_DIGIT 3

// digit steps to cover all of b, rounded up
`define GF_STEPS ((`GF_M + `GF_DIGIT - 1) / `GF_DIGIT)

// middle term of the polynomial, so x^97 folds to 2*x^12 + 1
`define GF_TAP 12

`endif
